//--- hw/meta_pkg.sv
// dispatch queue payload types
// one 30-bit fifo word, a kind tag plus a 29-bit body
// the body is read either as a packet descriptor or as a control command
// field widths fixed for four processing units

`default_nettype none

package meta_pkg;

	// ====================
	// field widths
	// ====================
	localparam int BUF_PTR_W = 16;
	localparam int LEN_W     = 11;
	localparam int PU_ID_W   = 2;

	typedef logic [PU_ID_W-1:0] pu_id_t;

	typedef enum logic {
		kind_pkt  = 1'b0,
		kind_ctrl = 1'b1
	} payload_kind_e;

	// packet descriptor, 29 bits
	typedef struct packed {
		logic [BUF_PTR_W-1:0] buf_ptr;
		logic [LEN_W-1:0]     len;
		pu_id_t               pu;
	} pkt_desc_t;

	// control command, 29 bits
	// op 1 enables the unit, op 0 disables it
	typedef struct packed {
		logic        op;
		pu_id_t      pu;
		logic [25:0] rsvd;
	} ctrl_cmd_t;

	// same 29 bits, two decodes
	typedef union packed {
		pkt_desc_t pkt;
		ctrl_cmd_t ctrl;
	} payload_body_u;

	// fifo word
	typedef struct packed {
		payload_kind_e kind;
		payload_body_u body;
	} pu_queue_payload_type;

endpackage

`default_nettype wire

//--- hw/pu_pkg.sv
// processing unit side definitions
// unit count, enable mask and the info sent with a start pulse
// start info widths follow the descriptor fields of meta_pkg

`default_nettype none

package pu_pkg;

	// ====================
	// unit constants
	// ====================
	localparam int NUM_PU = 4;

	// one bit per unit, also used for start and ready vectors
	typedef logic [NUM_PU-1:0] pu_mask_t;

	// ====================
	// start command
	// ====================
	// 27 bits, buffer pointer and length of the started packet
	typedef struct packed {
		logic [meta_pkg::BUF_PTR_W-1:0] buf_ptr;
		logic [meta_pkg::LEN_W-1:0]     len;
	} pu_start_t;

endpackage

`default_nettype wire

//--- hw/sfifo_ctrl.sv
// pointer and flag controller for a power-of-two synchronous fifo
// rd and wr must already be qualified by the caller
// a read on empty or a write on full corrupts the state
// flags are registered from the next-state count

`timescale 1ns/1ps
`default_nettype none

module sfifo_ctrl #(
	parameter int DEPTH_NBITS = 3
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   rd,
	input  logic                   wr,
	output logic [DEPTH_NBITS-1:0] rptr,
	output logic [DEPTH_NBITS-1:0] wptr,
	output logic [DEPTH_NBITS:0]   count,
	output logic                   full,
	output logic                   empty,
	output logic                   fullm1
);

	localparam int DEPTH = 1 << DEPTH_NBITS;

	localparam logic [DEPTH_NBITS:0] CNT_FULL   = (DEPTH_NBITS+1)'(DEPTH);
	localparam logic [DEPTH_NBITS:0] CNT_FULLM1 = (DEPTH_NBITS+1)'(DEPTH - 1);

	logic [DEPTH_NBITS:0] ncount;

	// ====================
	// next-state count
	// ====================
	always_comb begin
		case ({wr, rd})
			2'b10:   ncount = count + 1'b1;
			2'b01:   ncount = count - 1'b1;
			// both or neither leaves occupancy alone
			default: ncount = count;
		endcase
	end

	// ====================
	// pointers and flags
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rptr   <= '0;
			wptr   <= '0;
			count  <= '0;
			full   <= 1'b0;
			empty  <= 1'b1;
			fullm1 <= 1'b0;
		end else begin
			// pointers wrap naturally at the power-of-two depth
			if (rd) begin
				rptr <= rptr + 1'b1;
			end
			if (wr) begin
				wptr <= wptr + 1'b1;
			end
			count  <= ncount;
			full   <= (ncount == CNT_FULL);
			empty  <= (ncount == '0);
			fullm1 <= (ncount == CNT_FULLM1);
		end
	end

endmodule

`default_nettype wire

//--- hw/sfifo_pu_queue_payload.sv
// payload fifo with registered fall-through output
// inner fifo is the storage array plus sfifo_ctrl, outer stage holds the head
// dout is the head whenever empty is low
// total capacity is 2**DEPTH_NBITS, the head register counts as one entry
// rd must only be raised when empty is low, wr only when full is low

`timescale 1ns/1ps
`default_nettype none

module sfifo_pu_queue_payload #(
	parameter int DEPTH_NBITS = 3
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  meta_pkg::pu_queue_payload_type din,
	input  logic                           rd,
	input  logic                           wr,
	output meta_pkg::pu_queue_payload_type dout,
	output logic [DEPTH_NBITS:0]           count,
	output logic                           full,
	output logic                           empty
);

	localparam int DEPTH = 1 << DEPTH_NBITS;

	logic [DEPTH_NBITS-1:0] ff_rptr;
	logic [DEPTH_NBITS-1:0] ff_wptr;
	logic [DEPTH_NBITS:0]   ff_count;
	logic                   ff_empty;
	logic                   ff_fullm1;
	logic                   ff_rd;
	logic                   ff_wr;
	logic                   nempty;

	meta_pkg::pu_queue_payload_type ff_dout;
	meta_pkg::pu_queue_payload_type fifod [DEPTH];

	// ====================
	// inner fifo
	// ====================
	// pop the array only when it holds something behind the head
	assign ff_rd = rd & ~ff_empty;
	// write bypasses the array when the head is free or is being freed with nothing behind it
	assign ff_wr = wr & ~(empty | (ff_empty & rd));

	sfifo_ctrl #(
		.DEPTH_NBITS(DEPTH_NBITS)
	) u_sfifo_ctrl (
		.clk    (clk),
		.rst_n  (rst_n),
		.rd     (ff_rd),
		.wr     (ff_wr),
		.rptr   (ff_rptr),
		.wptr   (ff_wptr),
		.count  (ff_count),
		.full   (),
		.empty  (ff_empty),
		.fullm1 (ff_fullm1)
	);

	always_ff @(posedge clk) begin
		if (ff_wr) begin
			fifod[ff_wptr] <= din;
		end
	end

	assign ff_dout = fifod[ff_rptr];

	// ====================
	// head register
	// ====================
	// empty only when the last entry leaves without a refill
	assign nempty = (wr == rd) ? empty : (~wr & rd & ff_empty);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			empty <= 1'b1;
		end else begin
			empty <= nempty;
		end
	end

	// refill from the array when it has data, else take din directly
	always_ff @(posedge clk) begin
		if ((wr & empty) | rd) begin
			dout <= (rd & ~ff_empty) ? ff_dout : din;
		end
	end

	// ====================
	// outer status
	// ====================
	assign count = ff_count + {{DEPTH_NBITS{1'b0}}, ~empty};
	// array at depth-1 implies a held head, so the total is at depth
	assign full  = ff_fullm1;

endmodule

`default_nettype wire

//--- hw/pu_queue_writer.sv
// producer side of the dispatch queue
// wr and din are combinational from the strobes and full
// a command beats a descriptor in the same cycle, the descriptor is dropped
// drop_count saturates at all ones

`timescale 1ns/1ps
`default_nettype none

module pu_queue_writer (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           desc_valid,
	input  meta_pkg::pkt_desc_t            desc,
	input  logic                           cmd_valid,
	input  meta_pkg::ctrl_cmd_t            cmd,
	input  logic                           full,
	output logic                           wr,
	output meta_pkg::pu_queue_payload_type din,
	output logic [15:0]                    drop_count
);

	logic [1:0]  n_strobe;
	logic [1:0]  n_drop;
	logic [16:0] drop_sum;

	// ====================
	// payload select
	// ====================
	always_comb begin
		if (cmd_valid) begin
			din.kind      = meta_pkg::kind_ctrl;
			din.body.ctrl = cmd;
		end else begin
			din.kind     = meta_pkg::kind_pkt;
			din.body.pkt = desc;
		end
	end

	assign wr = (desc_valid | cmd_valid) & ~full;

	// ====================
	// drop accounting
	// ====================
	// strobes seen minus the one written, covers full and collision alike
	assign n_strobe = {1'b0, desc_valid} + {1'b0, cmd_valid};
	assign n_drop   = n_strobe - {1'b0, wr};
	assign drop_sum = {1'b0, drop_count} + {15'd0, n_drop};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			drop_count <= '0;
		end else if (drop_sum[16]) begin
			// saturate
			drop_count <= '1;
		end else begin
			drop_count <= drop_sum[15:0];
		end
	end

endmodule

`default_nettype wire

//--- hw/pu_dispatch.sv
// consumer side of the dispatch queue
// rd is combinational from the head entry, empty, pu_ready and enable_mask
// pu_start and start_info are registered one cycle after the pop
// head-of-line blocking while the head unit is enabled and not ready

`timescale 1ns/1ps
`default_nettype none

module pu_dispatch (
	input  logic                           clk,
	input  logic                           rst_n,
	input  meta_pkg::pu_queue_payload_type dout,
	input  logic                           empty,
	input  pu_pkg::pu_mask_t               pu_ready,
	output logic                           rd,
	output pu_pkg::pu_mask_t               pu_start,
	output pu_pkg::pu_start_t              start_info,
	output pu_pkg::pu_mask_t               enable_mask,
	output logic [15:0]                    discard_count
);

	logic is_pkt;
	logic is_cmd;
	logic pkt_en;
	logic start;
	logic discard;

	// ====================
	// head decode
	// ====================
	assign is_pkt  = ~empty & (dout.kind == meta_pkg::kind_pkt);
	assign is_cmd  = ~empty & (dout.kind == meta_pkg::kind_ctrl);
	assign pkt_en  = enable_mask[dout.body.pkt.pu];
	// disabled unit, drop without waiting on ready
	assign discard = is_pkt & ~pkt_en;
	assign start   = is_pkt & pkt_en & pu_ready[dout.body.pkt.pu];
	// commands never wait
	assign rd      = is_cmd | discard | start;

	// ====================
	// registered outputs
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pu_start      <= '0;
			enable_mask   <= '1;
			discard_count <= '0;
		end else begin
			pu_start <= '0;
			if (start) begin
				pu_start[dout.body.pkt.pu] <= 1'b1;
			end
			if (is_cmd) begin
				enable_mask[dout.body.ctrl.pu] <= dout.body.ctrl.op;
			end
			if (discard && discard_count != 16'hffff) begin
				discard_count <= discard_count + 1'b1;
			end
		end
	end

	// only meaningful alongside pu_start
	always_ff @(posedge clk) begin
		if (start) begin
			start_info.buf_ptr <= dout.body.pkt.buf_ptr;
			start_info.len     <= dout.body.pkt.len;
		end
	end

endmodule

`default_nettype wire

//--- hw/pu_queue_top.sv
// dispatch queue top level, writer into payload fifo into dispatcher
// DEPTH_NBITS sets the queue depth to 2**DEPTH_NBITS entries
// descriptor strobe to pu_start is two edges for an idle, ready, enabled unit

`timescale 1ns/1ps
`default_nettype none

module pu_queue_top #(
	parameter int DEPTH_NBITS = 3
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   desc_valid,
	input  meta_pkg::pkt_desc_t    desc,
	input  logic                   cmd_valid,
	input  meta_pkg::ctrl_cmd_t    cmd,
	input  pu_pkg::pu_mask_t       pu_ready,
	output pu_pkg::pu_mask_t       pu_start,
	output pu_pkg::pu_start_t      start_info,
	output pu_pkg::pu_mask_t       enable_mask,
	output logic [15:0]            drop_count,
	output logic [15:0]            discard_count,
	output logic [DEPTH_NBITS:0]   count
);

	logic                           wr;
	logic                           rd;
	logic                           full;
	logic                           empty;
	meta_pkg::pu_queue_payload_type din;
	meta_pkg::pu_queue_payload_type dout;

	pu_queue_writer u_writer (
		.clk        (clk),
		.rst_n      (rst_n),
		.desc_valid (desc_valid),
		.desc       (desc),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.full       (full),
		.wr         (wr),
		.din        (din),
		.drop_count (drop_count)
	);

	sfifo_pu_queue_payload #(
		.DEPTH_NBITS(DEPTH_NBITS)
	) u_queue (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (din),
		.rd    (rd),
		.wr    (wr),
		.dout  (dout),
		.count (count),
		.full  (full),
		.empty (empty)
	);

	pu_dispatch u_dispatch (
		.clk           (clk),
		.rst_n         (rst_n),
		.dout          (dout),
		.empty         (empty),
		.pu_ready      (pu_ready),
		.rd            (rd),
		.pu_start      (pu_start),
		.start_info    (start_info),
		.enable_mask   (enable_mask),
		.discard_count (discard_count)
	);

endmodule

`default_nettype wire

//--- tb/pu_queue_props.sv
// checks for the dispatch queue, bound into pu_queue_top
// exp_* inputs come from the testbench reference model
// model and dut outputs both settle after the same edge
// fail_count is read by the testbench at the end of the run

`timescale 1ns/1ps
`default_nettype none

module pu_queue_props #(
	parameter int CNT_W = 4
) (
	input logic                clk,
	input logic                rst_n,
	input pu_pkg::pu_mask_t    pu_start,
	input pu_pkg::pu_start_t   start_info,
	input pu_pkg::pu_mask_t    enable_mask,
	input logic [15:0]         drop_count,
	input logic [15:0]         discard_count,
	input logic [CNT_W-1:0]    count,
	input pu_pkg::pu_mask_t    exp_start,
	input pu_pkg::pu_start_t   exp_info,
	input pu_pkg::pu_mask_t    exp_mask,
	input logic [15:0]         exp_drop,
	input logic [15:0]         exp_discard,
	input logic [CNT_W-1:0]    exp_count
);

	int fail_count = 0;

	// ====================
	// reset state
	// ====================
	a_reset: assert property (@(posedge clk) $rose(rst_n) |-> (count == '0 && pu_start == '0
		&& enable_mask == '1 && drop_count == '0 && discard_count == '0))
	else begin
		$error("ERROR reset state wrong, count %h pu_start %h enable_mask %h", $sampled(count),
			$sampled(pu_start), $sampled(enable_mask));
		fail_count++;
	end

	// ====================
	// dispatch
	// ====================
	// expected start is one-hot for the head unit or zero
	a_start: assert property (@(posedge clk) rst_n |-> pu_start == exp_start)
	else begin
		$error("ERROR pu_start exp %h got %h", $sampled(exp_start), $sampled(pu_start));
		fail_count++;
	end

	// info only defined alongside a start
	a_info: assert property (@(posedge clk) (rst_n && exp_start != '0) |-> start_info == exp_info)
	else begin
		$error("ERROR start_info exp %h got %h", $sampled(exp_info), $sampled(start_info));
		fail_count++;
	end

	a_mask: assert property (@(posedge clk) rst_n |-> enable_mask == exp_mask)
	else begin
		$error("ERROR enable_mask exp %h got %h", $sampled(exp_mask), $sampled(enable_mask));
		fail_count++;
	end

	// ====================
	// occupancy and counters
	// ====================
	a_count: assert property (@(posedge clk) rst_n |-> count == exp_count)
	else begin
		$error("ERROR count exp %h got %h", $sampled(exp_count), $sampled(count));
		fail_count++;
	end

	a_drop: assert property (@(posedge clk) rst_n |-> drop_count == exp_drop)
	else begin
		$error("ERROR drop_count exp %h got %h", $sampled(exp_drop), $sampled(drop_count));
		fail_count++;
	end

	a_discard: assert property (@(posedge clk) rst_n |-> discard_count == exp_discard)
	else begin
		$error("ERROR discard_count exp %h got %h", $sampled(exp_discard),
			$sampled(discard_count));
		fail_count++;
	end

endmodule

`default_nettype wire

//--- tb/tb_pu_queue.sv
// testbench for the dispatch queue top level
// random traffic first, then directed back-pressure, disable and collision phases
// reference model keeps the accepted payloads in order, checks live in pu_queue_props
// inputs change 1 ns after the rising edge, the model samples them at the edge

`timescale 1ns/1ps
`default_nettype none

module tb_pu_queue;

	localparam int DEPTH_NBITS = 3;
	localparam int DEPTH       = 1 << DEPTH_NBITS;
	localparam int RAND_CYCLES = 200;
	// reset, random phase, then directed strobes and idle tail
	localparam int STIM_CYCLES = 8 + RAND_CYCLES + 29;
	localparam int TIMEOUT     = STIM_CYCLES + DEPTH * 4 + 100;

	logic                         clk;
	logic                         rst_n;
	logic                         desc_valid;
	logic                         cmd_valid;
	meta_pkg::pkt_desc_t          desc;
	meta_pkg::ctrl_cmd_t          cmd;
	pu_pkg::pu_mask_t             pu_ready;
	pu_pkg::pu_mask_t             pu_start;
	pu_pkg::pu_start_t            start_info;
	pu_pkg::pu_mask_t             enable_mask;
	logic [15:0]                  drop_count;
	logic [15:0]                  discard_count;
	logic [DEPTH_NBITS:0]         count;

	// reference model state and the expected values it exposes
	meta_pkg::pu_queue_payload_type model_q [$];
	meta_pkg::pu_queue_payload_type head;
	meta_pkg::pu_queue_payload_type ent;
	pu_pkg::pu_mask_t               m_mask;
	pu_pkg::pu_mask_t               start_v;
	pu_pkg::pu_start_t              info_v;
	pu_pkg::pu_mask_t               exp_start;
	pu_pkg::pu_start_t              exp_info;
	pu_pkg::pu_mask_t               exp_mask;
	logic [15:0]                    exp_drop;
	logic [15:0]                    exp_discard;
	logic [DEPTH_NBITS:0]           exp_count;
	int                             m_drop;
	int                             m_discard;
	int                             n_strobe;
	logic                           was_full;

	logic [31:0] rng;
	logic        saw_full;
	int          errs;
	int          total;
	int          cyc;

	pu_queue_top #(
		.DEPTH_NBITS(DEPTH_NBITS)
	) uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.desc_valid    (desc_valid),
		.desc          (desc),
		.cmd_valid     (cmd_valid),
		.cmd           (cmd),
		.pu_ready      (pu_ready),
		.pu_start      (pu_start),
		.start_info    (start_info),
		.enable_mask   (enable_mask),
		.drop_count    (drop_count),
		.discard_count (discard_count),
		.count         (count)
	);

	bind pu_queue_top pu_queue_props #(
		.CNT_W (DEPTH_NBITS + 1)
	) u_props (
		.clk           (clk),
		.rst_n         (rst_n),
		.pu_start      (pu_start),
		.start_info    (start_info),
		.enable_mask   (enable_mask),
		.drop_count    (drop_count),
		.discard_count (discard_count),
		.count         (count),
		.exp_start     (tb_pu_queue.exp_start),
		.exp_info      (tb_pu_queue.exp_info),
		.exp_mask      (tb_pu_queue.exp_mask),
		.exp_drop      (tb_pu_queue.exp_drop),
		.exp_discard   (tb_pu_queue.exp_discard),
		.exp_count     (tb_pu_queue.exp_count)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ====================
	// reference model
	// ====================
	always @(posedge clk) begin
		if (!rst_n) begin
			model_q.delete();
			m_mask      = '1;
			m_drop      = 0;
			m_discard   = 0;
			exp_start   <= '0;
			exp_mask    <= '1;
			exp_drop    <= '0;
			exp_discard <= '0;
			exp_count   <= '0;
		end else begin
			start_v  = '0;
			info_v   = exp_info;
			// full is judged on the occupancy before this edge
			was_full = (model_q.size() == DEPTH);
			// at most one head entry leaves per edge
			if (model_q.size() != 0) begin
				head = model_q[0];
				if (head.kind == meta_pkg::kind_ctrl) begin
					m_mask[head.body.ctrl.pu] = head.body.ctrl.op;
					void'(model_q.pop_front());
				end else if (!m_mask[head.body.pkt.pu]) begin
					m_discard = (m_discard < 16'hffff) ? m_discard + 1 : m_discard;
					void'(model_q.pop_front());
				end else if (pu_ready[head.body.pkt.pu]) begin
					start_v[head.body.pkt.pu] = 1'b1;
					info_v.buf_ptr = head.body.pkt.buf_ptr;
					info_v.len     = head.body.pkt.len;
					void'(model_q.pop_front());
				end
			end
			// command wins a collision, every other strobe is a drop
			n_strobe = int'(desc_valid) + int'(cmd_valid);
			if (n_strobe != 0 && !was_full) begin
				if (cmd_valid) begin
					ent.kind      = meta_pkg::kind_ctrl;
					ent.body.ctrl = cmd;
				end else begin
					ent.kind     = meta_pkg::kind_pkt;
					ent.body.pkt = desc;
				end
				model_q.push_back(ent);
				n_strobe = n_strobe - 1;
			end
			m_drop = m_drop + n_strobe;
			if (m_drop > 16'hffff) begin
				m_drop = 16'hffff;
			end
			exp_start   <= start_v;
			exp_info    <= info_v;
			exp_mask    <= m_mask;
			exp_drop    <= 16'(m_drop);
			exp_discard <= 16'(m_discard);
			exp_count   <= (DEPTH_NBITS+1)'(model_q.size());
		end
	end

	always @(negedge clk) begin
		if (rst_n && count == DEPTH) begin
			saw_full = 1'b1;
		end
	end

	// ====================
	// stimulus helpers
	// ====================
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic send_desc(input meta_pkg::pu_id_t pu, input logic [15:0] ptr);
		desc_valid   = 1'b1;
		desc.buf_ptr = ptr;
		desc.len     = 11'(ptr ^ 16'h5a5);
		desc.pu      = pu;
		next_cycle();
		desc_valid = 1'b0;
	endtask

	task automatic send_cmd(input logic op, input meta_pkg::pu_id_t pu);
		cmd_valid = 1'b1;
		cmd.op    = op;
		cmd.pu    = pu;
		cmd.rsvd  = '0;
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	// both strobes in one cycle, an enable command and a descriptor for the same unit
	task automatic send_collision(input meta_pkg::pu_id_t pu, input logic [15:0] ptr);
		desc_valid   = 1'b1;
		desc.buf_ptr = ptr;
		desc.len     = 11'(ptr ^ 16'h5a5);
		desc.pu      = pu;
		cmd_valid    = 1'b1;
		cmd.op       = 1'b1;
		cmd.pu       = pu;
		cmd.rsvd     = '0;
		next_cycle();
		desc_valid = 1'b0;
		cmd_valid  = 1'b0;
	endtask

	// queue empties in a few cycles once every unit is ready
	task automatic wait_drain();
		while (count != '0) begin
			next_cycle();
		end
	endtask

	// cycle counter watchdog
	initial begin
		cyc = 0;
		while (cyc < TIMEOUT) begin
			@(posedge clk);
			cyc++;
		end
		$display("timeout after %0d cycles, the queue never drained", cyc);
		$display("** FAIL **");
		$finish;
	end

	// ====================
	// main sequence
	// ====================
	initial begin
		rst_n      = 1'b0;
		desc_valid = 1'b0;
		cmd_valid  = 1'b0;
		desc       = '0;
		cmd        = '0;
		pu_ready   = '1;
		rng        = 32'h84dd8d7a;
		saw_full   = 1'b0;
		errs       = 0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// random traffic, collisions about one cycle in 32
		repeat (RAND_CYCLES) begin
			rng          = xorshift32(rng);
			desc_valid   = rng[0];
			cmd_valid    = (rng[4:1] == 4'd0);
			cmd.op       = rng[5];
			cmd.pu       = rng[7:6];
			cmd.rsvd     = '0;
			pu_ready     = rng[11:8] | rng[15:12];
			desc.buf_ptr = rng[31:16];
			desc.len     = {rng[20:16], rng[5:0]};
			desc.pu      = rng[19:18];
			next_cycle();
		end
		desc_valid = 1'b0;
		cmd_valid  = 1'b0;
		pu_ready   = '1;
		wait_drain();

		// back-pressure, unit 0 held not ready, last four strobes drop
		for (int i = 0; i < 4; i++) begin
			send_cmd(1'b1, meta_pkg::pu_id_t'(i));
		end
		pu_ready = '0;
		for (int i = 0; i < 12; i++) begin
			send_desc(2'd0, 16'(16'h1000 + i));
		end
		pu_ready = '1;
		wait_drain();

		// disable unit 1, discard its descriptors, then re-enable
		send_cmd(1'b0, 2'd1);
		for (int i = 0; i < 4; i++) begin
			send_desc(2'd1, 16'(16'h2000 + i));
		end
		send_cmd(1'b1, 2'd1);
		for (int i = 0; i < 3; i++) begin
			send_desc(2'd1, 16'(16'h3000 + i));
		end

		// collision, command queued and descriptor dropped
		send_collision(2'd2, 16'h4000);
		wait_drain();
		repeat (3) next_cycle();

		// ====================
		// end checks
		// ====================
		if (drop_count !== exp_drop) begin
			$display("ERROR drop_count exp %h got %h", exp_drop, drop_count);
			errs++;
		end
		if (discard_count !== exp_discard) begin
			$display("ERROR discard_count exp %h got %h", exp_discard, discard_count);
			errs++;
		end
		if (count !== '0 || model_q.size() != 0) begin
			$display("queue not empty at the end, model still holds %0d entries",
				model_q.size());
			errs++;
		end
		if (!saw_full) begin
			$display("queue never reached full during the back-pressure phase");
			errs++;
		end
		total = errs + uut.u_props.fail_count;
		$display("summary: %0d assertion failures, %0d end check errors",
			uut.u_props.fail_count, errs);
		if (total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
hw/meta_pkg.sv
hw/pu_pkg.sv
hw/sfifo_ctrl.sv
hw/sfifo_pu_queue_payload.sv
hw/pu_queue_writer.sv
hw/pu_dispatch.sv
hw/pu_queue_top.sv
tb/pu_queue_props.sv
tb/tb_pu_queue.sv
